//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_matrix_control
RTL_TOP    ?= matrix_control_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST)) hw/matrix_defines.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
+incdir+hw
hw/matrix_pkg.sv
hw/pixel_write_if.sv
hw/row_loader.sv
hw/pixel_loader.sv
hw/command_decoder.sv
hw/frame_buffer.sv
hw/matrix_control_top.sv
test/clock_gen.sv
test/tb_matrix_control.sv

//--- hw/command_decoder.sv
`include "matrix_defines.svh"

module command_decoder (
    input  logic                          clk_in,
    input  logic                          reset,
    input  logic                          byte_valid,
    input  logic [7:0]                    rx_data,
    output logic [2:0]                    rgb_enable,
    output logic [`BRIGHTNESS_LEVELS-1:0] brightness_enable,
    pixel_write_if.source                 fb_write
);
    matrix_pkg::cmd_state_t        state;
    logic [`BRIGHTNESS_LEVELS-1:0] toggle_mask;
    logic                          row_enable;
    logic                          pixel_enable;
    logic                          row_done;
    logic                          pixel_done;

    pixel_write_if row_wr ();
    pixel_write_if pixel_wr ();

    assign row_enable = (state == matrix_pkg::read_row);
    assign pixel_enable = (state == matrix_pkg::read_pixel);

    row_loader row_loader_i (
        .clk_in     (clk_in),
        .reset      (reset),
        .enable     (row_enable),
        .byte_valid (byte_valid),
        .rx_data    (rx_data),
        .done       (row_done),
        .wr         (row_wr.source)
    );

    pixel_loader pixel_loader_i (
        .clk_in     (clk_in),
        .reset      (reset),
        .enable     (pixel_enable),
        .byte_valid (byte_valid),
        .rx_data    (rx_data),
        .done       (pixel_done),
        .wr         (pixel_wr.source)
    );

    // digit n flips bit BRIGHTNESS_LEVELS - n
    always_comb begin
        toggle_mask = '0;
        for (int i = 1; i <= `BRIGHTNESS_LEVELS; i++) begin
            if (rx_data[3:0] == 4'(i)) begin
                toggle_mask[`BRIGHTNESS_LEVELS-i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= matrix_pkg::idle;
            rgb_enable <= 3'b111;
            brightness_enable <= '1;
        end else if (byte_valid) begin
            case (state)
                matrix_pkg::idle: begin
                    case (rx_data)
                        matrix_pkg::op_red_on:    rgb_enable[0] <= 1'b1;
                        matrix_pkg::op_red_off:   rgb_enable[0] <= 1'b0;
                        matrix_pkg::op_green_on:  rgb_enable[1] <= 1'b1;
                        matrix_pkg::op_green_off: rgb_enable[1] <= 1'b0;
                        matrix_pkg::op_blue_on:   rgb_enable[2] <= 1'b1;
                        matrix_pkg::op_blue_off:  rgb_enable[2] <= 1'b0;
                        matrix_pkg::op_digit_1, matrix_pkg::op_digit_2,
                        matrix_pkg::op_digit_3, matrix_pkg::op_digit_4,
                        matrix_pkg::op_digit_5, matrix_pkg::op_digit_6: begin
                            brightness_enable <= brightness_enable ^ toggle_mask;
                        end
                        matrix_pkg::op_digit_0:    brightness_enable <= '0;
                        matrix_pkg::op_digit_9:    brightness_enable <= '1;
                        matrix_pkg::op_brightness: state <= matrix_pkg::read_brightness;
                        matrix_pkg::op_row:        state <= matrix_pkg::read_row;
                        matrix_pkg::op_pixel:      state <= matrix_pkg::read_pixel;
                        default: ; // unknown bytes are dropped
                    endcase
                end
                matrix_pkg::read_brightness: begin
                    brightness_enable <= rx_data[`BRIGHTNESS_LEVELS-1:0];
                    state <= matrix_pkg::idle;
                end
                matrix_pkg::read_row: begin
                    if (row_done) begin
                        state <= matrix_pkg::idle;
                    end
                end
                matrix_pkg::read_pixel: begin
                    if (pixel_done) begin
                        state <= matrix_pkg::idle;
                    end
                end
                default: state <= matrix_pkg::idle;
            endcase
        end
    end

    // only the active loader reaches the frame buffer
    always_comb begin
        fb_write.write_enable = 1'b0;
        fb_write.row = row_wr.row;
        fb_write.column = row_wr.column;
        fb_write.byte_sel = row_wr.byte_sel;
        fb_write.data = row_wr.data;
        case (state)
            matrix_pkg::read_row: begin
                fb_write.write_enable = row_wr.write_enable;
            end
            matrix_pkg::read_pixel: begin
                fb_write.write_enable = pixel_wr.write_enable;
                fb_write.row = pixel_wr.row;
                fb_write.column = pixel_wr.column;
                fb_write.byte_sel = pixel_wr.byte_sel;
                fb_write.data = pixel_wr.data;
            end
            default: ;
        endcase
    end

endmodule

//--- hw/frame_buffer.sv
`include "matrix_defines.svh"

module frame_buffer (
    input  logic                     clk_in,
    pixel_write_if.sink              wr,
    input  logic [`FB_ADDR_BITS-1:0] rd_address,
    output logic [7:0]               rd_data
);
    logic [7:0]               mem [`FB_DEPTH];
    logic [`FB_ADDR_BITS-1:0] wr_address;

    // first byte of a pixel goes to the odd address, so pixels are little-endian
    assign wr_address = {wr.row, wr.column, ~wr.byte_sel};

    always_ff @(posedge clk_in) begin
        if (wr.write_enable) begin
            mem[wr_address] <= wr.data;
        end
    end

    // registered read, old data on a same-address collision
    always_ff @(posedge clk_in) begin
        rd_data <= mem[rd_address];
    end

endmodule

//--- hw/matrix_control_top.sv
`include "matrix_defines.svh"

module matrix_control_top (
    input  logic                          clk_in,
    input  logic                          reset,
    input  logic                          byte_valid,
    input  logic [7:0]                    rx_data,
    output logic [2:0]                    rgb_enable,
    output logic [`BRIGHTNESS_LEVELS-1:0] brightness_enable,
    input  logic [`FB_ADDR_BITS-1:0]      rd_address,
    output logic [7:0]                    rd_data
);
    pixel_write_if fb_write ();

    command_decoder command_decoder_i (
        .clk_in            (clk_in),
        .reset             (reset),
        .byte_valid        (byte_valid),
        .rx_data           (rx_data),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .fb_write          (fb_write.source)
    );

    // read side goes straight out to the scanner
    frame_buffer frame_buffer_i (
        .clk_in     (clk_in),
        .wr         (fb_write.sink),
        .rd_address (rd_address),
        .rd_data    (rd_data)
    );

endmodule

//--- hw/matrix_defines.svh
`ifndef MATRIX_DEFINES_SVH
`define MATRIX_DEFINES_SVH

// panel geometry
`define MATRIX_WIDTH 16
`define MATRIX_HEIGHT 8
`define BYTES_PER_PIXEL 2

// bits in the brightness mask
`define BRIGHTNESS_LEVELS 6

`define ROW_BITS $clog2(`MATRIX_HEIGHT)
`define COL_BITS $clog2(`MATRIX_WIDTH)
`define BYTE_SEL_BITS $clog2(`BYTES_PER_PIXEL)
`define FB_ADDR_BITS (`ROW_BITS + `COL_BITS + `BYTE_SEL_BITS)
`define FB_DEPTH (`MATRIX_WIDTH * `MATRIX_HEIGHT * `BYTES_PER_PIXEL)

`endif

//--- hw/matrix_pkg.sv
package matrix_pkg;

    typedef enum logic [1:0] {
        idle,
        read_brightness,
        read_row,
        read_pixel
    } cmd_state_t;

    // ascii command bytes
    typedef enum logic [7:0] {
        op_red_on    = 8'h52, // R
        op_red_off   = 8'h72, // r
        op_green_on  = 8'h47, // G
        op_green_off = 8'h67, // g
        op_blue_on   = 8'h42, // B
        op_blue_off  = 8'h62, // b
        op_digit_0   = 8'h30,
        op_digit_1   = 8'h31,
        op_digit_2   = 8'h32,
        op_digit_3   = 8'h33,
        op_digit_4   = 8'h34,
        op_digit_5   = 8'h35,
        op_digit_6   = 8'h36,
        op_digit_7   = 8'h37,
        op_digit_8   = 8'h38,
        op_digit_9   = 8'h39,
        op_brightness = 8'h54, // T, one argument byte
        op_row       = 8'h4c, // L
        op_pixel     = 8'h50  // P
    } cmd_opcode_t;

endpackage

//--- hw/pixel_loader.sv
`include "matrix_defines.svh"

module pixel_loader (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       enable,
    input  logic       byte_valid,
    input  logic [7:0] rx_data,
    output logic       done,
    pixel_write_if.source wr
);
    // 0 row, 1 column, 2 first data byte, 3 second data byte
    logic [1:0]           phase;
    logic [`ROW_BITS-1:0] row;
    logic [`COL_BITS-1:0] column;
    logic                 data_write;

    assign data_write = enable && byte_valid && phase[1];

    always_ff @(posedge clk_in) begin
        if (reset || !enable) begin
            phase <= 2'd0;
        end else if (byte_valid) begin
            phase <= phase + 2'd1; // wraps back to 0 after the last byte
        end
    end

    // row and column are used modulo the panel size
    always_ff @(posedge clk_in) begin
        if (enable && byte_valid) begin
            if (phase == 2'd0) begin
                row <= rx_data[`ROW_BITS-1:0];
            end
            if (phase == 2'd1) begin
                column <= rx_data[`COL_BITS-1:0];
            end
        end
    end

    assign wr.write_enable = data_write;
    assign wr.row = row;
    assign wr.column = column;
    assign wr.byte_sel = phase[0];
    assign wr.data = rx_data;

    assign done = data_write && phase[0];

endmodule

//--- hw/pixel_write_if.sv
`include "matrix_defines.svh"

interface pixel_write_if;
    logic                  write_enable;
    logic [`ROW_BITS-1:0]  row;
    logic [`COL_BITS-1:0]  column;
    logic                  byte_sel; // 0 for the first byte of a pixel
    logic [7:0]            data;

    modport source (
        output write_enable,
        output row,
        output column,
        output byte_sel,
        output data
    );

    modport sink (
        input write_enable,
        input row,
        input column,
        input byte_sel,
        input data
    );
endinterface

//--- hw/row_loader.sv
`include "matrix_defines.svh"

module row_loader (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       enable,
    input  logic       byte_valid,
    input  logic [7:0] rx_data,
    output logic       done,
    pixel_write_if.source wr
);
    logic                 have_row;
    logic [`ROW_BITS-1:0] row;
    logic [`COL_BITS:0]   byte_count; // column plus byte select
    logic                 data_write;
    logic                 last_byte;

    assign data_write = enable && byte_valid && have_row;
    // count covers 2 * width bytes, so all ones marks the end of the row
    assign last_byte = &byte_count;

    always_ff @(posedge clk_in) begin
        if (reset || !enable) begin
            have_row <= 1'b0;
            byte_count <= '0;
        end else if (byte_valid) begin
            if (!have_row) begin
                have_row <= 1'b1;
            end else begin
                byte_count <= byte_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (enable && byte_valid && !have_row) begin
            row <= rx_data[`ROW_BITS-1:0]; // wraps modulo height
        end
    end

    assign wr.write_enable = data_write;
    assign wr.row = row;
    assign wr.column = byte_count[`COL_BITS:1];
    assign wr.byte_sel = byte_count[0];
    assign wr.data = rx_data;

    assign done = data_write && last_byte;

endmodule

//--- test/clock_gen.sv
module clock_gen (
    output logic clk_in,
    output logic reset
);
    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0; // released on a falling edge like the other inputs
    end
endmodule

//--- test/tb_matrix_control.sv
`include "matrix_defines.svh"

module tb_matrix_control;
    localparam int W = `MATRIX_WIDTH;
    localparam int H = `MATRIX_HEIGHT;
    localparam int N_COLOR = 40;
    localparam int N_BRIGHT = 40;
    localparam int N_PIXEL = 12;
    localparam int N_RAND_ROWS = 4;
    // bytes plus read cycles over all tests, framing test included in the slack
    localparam int TOTAL_ITEMS = N_COLOR + 2 * N_BRIGHT + 7 * N_PIXEL + H * (2 + 2 * W)
        + N_RAND_ROWS * (2 + 4 * W) + `FB_DEPTH + 100;
    localparam int WATCHDOG_TIME = 2 * TOTAL_ITEMS * 5 * 10;

    logic                          clk_in;
    logic                          reset;
    logic                          byte_valid;
    logic [7:0]                    rx_data;
    logic [2:0]                    rgb_enable;
    logic [`BRIGHTNESS_LEVELS-1:0] brightness_enable;
    logic [`FB_ADDR_BITS-1:0]      rd_address;
    logic [7:0]                    rd_data;
    // shadow model
    matrix_pkg::cmd_state_t        exp_state;
    logic [2:0]                    exp_rgb;
    logic [`BRIGHTNESS_LEVELS-1:0] exp_bright;
    logic [7:0]                    shadow [`FB_DEPTH];
    int                            arg_count;
    int                            arg_row;
    int                            arg_col;
    logic [7:0]                    rd_expect;
    logic                          rd_check;
    int                            test_fails;
    int                            tests_passed;
    int                            tests_failed;

    clock_gen clock_gen_i (.clk_in(clk_in), .reset(reset));

    matrix_control_top dut_i (
        .clk_in            (clk_in),
        .reset             (reset),
        .byte_valid        (byte_valid),
        .rx_data           (rx_data),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .rd_address        (rd_address),
        .rd_data           (rd_data)
    );

    function automatic void flag_error(string msg);
        test_fails++;
        $display("ERR %0t: %s", $time, msg);
    endfunction

    reset_values: assert property (@(posedge clk_in) $fell(reset) |->
        rgb_enable == 3'b111 && brightness_enable == '1)
        else flag_error("outputs are not all ones after reset");

    outputs_follow: assert property (@(posedge clk_in) disable iff (reset)
        byte_valid |=> rgb_enable == exp_rgb && brightness_enable == exp_bright)
        else flag_error($sformatf("rgb %b brightness %b, model %b %b",
            rgb_enable, brightness_enable, exp_rgb, exp_bright));

    read_back: assert property (@(posedge clk_in) disable iff (reset)
        rd_check |=> rd_data == $past(rd_expect))
        else flag_error($sformatf("read-back mismatch, rd_data %h", rd_data));

    // first byte of a pixel at the odd address
    function automatic int pixel_address(int row, int col, int sel);
        return row * W * 2 + col * 2 + (1 - sel);
    endfunction

    function automatic bit is_command(logic [7:0] b);
        return b inside {[8'h30:8'h39], "R", "r", "G", "g", "B", "b", "T", "L", "P"};
    endfunction

    task automatic model_byte(input logic [7:0] b);
        case (exp_state)
            matrix_pkg::idle: begin
                arg_count = 0;
                case (b)
                    matrix_pkg::op_red_on:     exp_rgb[0] = 1'b1;
                    matrix_pkg::op_red_off:    exp_rgb[0] = 1'b0;
                    matrix_pkg::op_green_on:   exp_rgb[1] = 1'b1;
                    matrix_pkg::op_green_off:  exp_rgb[1] = 1'b0;
                    matrix_pkg::op_blue_on:    exp_rgb[2] = 1'b1;
                    matrix_pkg::op_blue_off:   exp_rgb[2] = 1'b0;
                    matrix_pkg::op_digit_0:    exp_bright = '0;
                    matrix_pkg::op_digit_9:    exp_bright = '1;
                    matrix_pkg::op_brightness: exp_state = matrix_pkg::read_brightness;
                    matrix_pkg::op_row:        exp_state = matrix_pkg::read_row;
                    matrix_pkg::op_pixel:      exp_state = matrix_pkg::read_pixel;
                    default: begin
                        if (b >= 8'h31 && b <= 8'h36) begin
                            exp_bright[`BRIGHTNESS_LEVELS - int'(b - 8'h30)] ^= 1'b1;
                        end
                    end
                endcase
            end
            matrix_pkg::read_brightness: begin
                exp_bright = b[`BRIGHTNESS_LEVELS-1:0];
                exp_state = matrix_pkg::idle;
            end
            matrix_pkg::read_row: begin
                if (arg_count == 0) begin
                    arg_row = b % H;
                end else begin
                    shadow[pixel_address(arg_row, (arg_count - 1) / 2, (arg_count - 1) % 2)] = b;
                    if (arg_count == 2 * W) begin
                        exp_state = matrix_pkg::idle;
                    end
                end
                arg_count++;
            end
            default: begin
                case (arg_count)
                    0: arg_row = b % H;
                    1: arg_col = b % W;
                    default: shadow[pixel_address(arg_row, arg_col, arg_count - 2)] = b;
                endcase
                if (arg_count == 3) begin
                    exp_state = matrix_pkg::idle;
                end
                arg_count++;
            end
        endcase
    endtask

    // called on a falling edge, returns on the next one
    task automatic send_byte(input logic [7:0] b);
        byte_valid = 1'b1;
        rx_data = b;
        @(negedge clk_in);
        byte_valid = 1'b0;
        model_byte(b);
    endtask

    task automatic send_gapped(input logic [7:0] b);
        send_byte(b);
        repeat ($urandom_range(3, 0)) @(negedge clk_in);
    endtask

    task automatic read_byte(input int addr);
        rd_address = addr[`FB_ADDR_BITS-1:0];
        rd_expect = shadow[addr];
        rd_check = 1'b1;
        @(negedge clk_in);
        rd_check = 1'b0;
    endtask

    // last data byte goes out with no gap after it
    task automatic send_row(input logic [7:0] row_byte);
        send_gapped(matrix_pkg::op_row);
        send_gapped(row_byte);
        for (int i = 0; i < 2 * W - 1; i++) begin
            send_gapped(8'($urandom));
        end
        send_byte(8'($urandom));
    endtask

    task automatic check_row(input int row);
        for (int a = row * 2 * W; a < (row + 1) * 2 * W; a++) begin
            read_byte(a);
        end
    endtask

    task automatic end_test(input string name);
        repeat (2) @(negedge clk_in); // let the last checks fire
        if (test_fails == 0) begin
            tests_passed++;
            $display("test %-10s ok", name);
        end else begin
            tests_failed++;
            $display("test %-10s failed with %0d errors", name, test_fails);
        end
        test_fails = 0;
    endtask

    initial begin
        logic [7:0] b;
        logic [7:0] color_ops [6];
        int         k;
        int         row;
        int         col;
        void'($urandom(32'h74cc));
        byte_valid = 1'b0;
        rx_data = 8'h00;
        rd_address = '0;
        rd_check = 1'b0;
        rd_expect = 8'h00;
        exp_state = matrix_pkg::idle;
        exp_rgb = 3'b111;
        exp_bright = '1;
        arg_count = 0;
        arg_row = 0;
        arg_col = 0;
        test_fails = 0;
        tests_passed = 0;
        tests_failed = 0;
        color_ops = '{matrix_pkg::op_red_on, matrix_pkg::op_red_off, matrix_pkg::op_green_on,
            matrix_pkg::op_green_off, matrix_pkg::op_blue_on, matrix_pkg::op_blue_off};
        @(negedge reset);
        @(negedge clk_in);
        end_test("reset");

        for (int i = 0; i < N_COLOR; i++) begin
            send_gapped(color_ops[$urandom_range(5, 0)]);
        end
        end_test("color");

        for (int i = 0; i < N_BRIGHT; i++) begin
            k = $urandom_range(9, 0);
            if (k < 6) begin
                send_gapped(8'h31 + 8'(k));
            end else if (k == 6) begin
                send_gapped(matrix_pkg::op_digit_0);
            end else if (k == 7) begin
                send_gapped(matrix_pkg::op_digit_9);
            end else begin
                send_gapped(matrix_pkg::op_brightness);
                send_gapped(8'($urandom));
            end
        end
        end_test("brightness");

        for (int i = 0; i < N_PIXEL; i++) begin
            row = $urandom_range(255, 0); // wraps past the panel size
            col = $urandom_range(255, 0);
            send_gapped(matrix_pkg::op_pixel);
            send_gapped(8'(row));
            send_gapped(8'(col));
            send_gapped(8'($urandom));
            send_gapped(8'($urandom));
            read_byte(pixel_address(row % H, col % W, 0));
            read_byte(pixel_address(row % H, col % W, 1));
        end
        end_test("pixel");

        // fill every row first so the whole buffer is known
        for (int r = 0; r < H; r++) begin
            send_row(8'(r));
        end
        for (int i = 0; i < N_RAND_ROWS; i++) begin
            row = $urandom_range(255, 0);
            send_row(8'(row));
            check_row(row % H);
        end
        for (int a = 0; a < `FB_DEPTH; a++) begin
            read_byte(a);
        end
        end_test("row");

        for (int i = 0; i < 12; i++) begin
            b = 8'($urandom);
            while (is_command(b)) begin
                b = b + 8'd1;
            end
            send_gapped(b);
        end
        // known colors so every command below flips an output bit
        send_gapped(matrix_pkg::op_red_on);
        send_gapped(matrix_pkg::op_blue_on);
        send_row(8'($urandom));
        send_byte(matrix_pkg::op_red_off); // right after the last row byte
        send_byte(matrix_pkg::op_red_on);
        send_gapped(matrix_pkg::op_pixel);
        send_gapped(matrix_pkg::op_green_on);
        send_gapped(matrix_pkg::op_blue_off);
        send_gapped(matrix_pkg::op_red_off);
        send_byte(matrix_pkg::op_green_off);
        send_byte(matrix_pkg::op_blue_off);
        read_byte(pixel_address(8'h47 % H, 8'h62 % W, 0));
        read_byte(pixel_address(8'h47 % H, 8'h62 % W, 1));
        send_byte(matrix_pkg::op_brightness);
        send_byte(matrix_pkg::op_blue_on); // letter as the T argument
        end_test("framing");

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired after %0d time units, run stopped", WATCHDOG_TIME);
        $display("SOME TESTS FAILED");
        $finish;
    end
endmodule
